// File: common/nand_cpu_pkg.sv
package nand_cpu_pkg;

    // ########################################################################
    // Operations
    // ########################################################################

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_NAND = 3'd1,
        ALU_ADDI = 3'd2,
        ALU_LI   = 3'd3,
        ALU_MUL  = 3'd4
    } alu_op_t;

    // ########################################################################
    // Widths and latencies
    // ########################################################################

    localparam int NUM_REGS   = 8;
    localparam int REG_AW     = $clog2(NUM_REGS);
    localparam int DATA_W     = 16;
    localparam int IMM_W      = 6;
    localparam int OP_W       = 3;
    localparam int MUL_CYCLES = 4;

    // ########################################################################
    // Instruction word layout
    // ########################################################################

    // Each field starts at the given bit and runs upward.
    localparam int INSTR_W = 18;
    localparam int OP_POS  = 15;
    localparam int RW_POS  = 12;
    localparam int RA_POS  = 9;
    localparam int RT_POS  = 6;
    localparam int IMM_POS = 0;

endpackage

// File: common/issue_ifc.sv
`timescale 1ns/1ps

interface issue_ifc;
    import nand_cpu_pkg::*;

    logic              valid;
    logic              ready;
    alu_op_t           alu_op;
    logic [IMM_W-1:0]  immdt;
    logic              use_ra;
    logic [REG_AW-1:0] ra_addr;
    logic              use_rt;
    logic [REG_AW-1:0] rt_addr;
    logic [REG_AW-1:0] rw_addr;

    // A transfer takes place on a rising edge with valid and ready both high.
    modport sender (
        output valid, alu_op, immdt, use_ra, ra_addr, use_rt, rt_addr, rw_addr,
        input  ready
    );

    modport receiver (
        input  valid, alu_op, immdt, use_ra, ra_addr, use_rt, rt_addr, rw_addr,
        output ready
    );

endinterface

// File: logic/wb_dispatch.sv
`timescale 1ns/1ps

module wb_dispatch #(
    parameter int NUM_REGS = nand_cpu_pkg::NUM_REGS
) (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [31:0]                      wb_dat_i,
    output logic                             wb_ack,
    input  logic [NUM_REGS-1:0]              pending,
    input  logic [NUM_REGS-1:0]              src_busy,
    output logic                             reserve_en,
    output logic [nand_cpu_pkg::REG_AW-1:0]  reserve_addr,
    issue_ifc.sender                         dispatch
);
    import nand_cpu_pkg::*;

    typedef enum logic {
        IDLE,
        ACK
    } state_t;

    state_t             state;
    logic [INSTR_W-1:0] instr;
    logic               accept;

    assign instr = wb_dat_i[INSTR_W-1:0];

    always_comb begin
        dispatch.alu_op  = alu_op_t'(instr[OP_POS +: OP_W]);
        dispatch.immdt   = instr[IMM_POS +: IMM_W];
        dispatch.rw_addr = instr[RW_POS +: REG_AW];
        dispatch.ra_addr = instr[RA_POS +: REG_AW];
        dispatch.rt_addr = instr[RT_POS +: REG_AW];
        dispatch.use_ra  = (dispatch.alu_op != ALU_LI);
        dispatch.use_rt  = (dispatch.alu_op == ALU_ADD) || (dispatch.alu_op == ALU_NAND) ||
                           (dispatch.alu_op == ALU_MUL);
    end

    // A write is held off while the buffer is full, the destination still
    // waits for an earlier result, or a queued entry has yet to read it.
    assign accept = wb_cyc & wb_stb &
                    (~wb_we | (dispatch.ready & ~pending[dispatch.rw_addr] &
                               ~src_busy[dispatch.rw_addr]));

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    state <= accept ? ACK : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign wb_ack         = (state == ACK);
    assign dispatch.valid = (state == ACK) & wb_we;
    assign reserve_en     = dispatch.valid & dispatch.ready;
    assign reserve_addr   = dispatch.rw_addr;

endmodule

// File: execution_buffer/execution_buffer.sv
`timescale 1ns/1ps

module execution_buffer #(
    parameter int L        = 8,
    parameter int NUM_REGS = nand_cpu_pkg::NUM_REGS
) (
    input  logic                clk,
    input  logic                n_rst,
    input  logic [NUM_REGS-1:0] pending,
    output logic [NUM_REGS-1:0] src_busy,
    issue_ifc.receiver          in,
    issue_ifc.sender            out
);
    import nand_cpu_pkg::*;

    localparam int IDX_W = $clog2(L);

    typedef struct packed {
        alu_op_t           alu_op;
        logic [IMM_W-1:0]  immdt;
        logic              use_ra;
        logic [REG_AW-1:0] ra_addr;
        logic              ra_ok;
        logic              use_rt;
        logic [REG_AW-1:0] rt_addr;
        logic              rt_ok;
        logic [REG_AW-1:0] rw_addr;
    } entry_t;

    entry_t            slots [L];
    logic [L-1:0]      vld;
    logic [L-1:0]      slot_rdy;
    logic              any_rdy;
    logic [IDX_W-1:0]  sel_idx;
    logic              any_open;
    logic [IDX_W-1:0]  open_idx;
    logic              fill;
    logic              issue_fire;

    // ########################################################################
    // Wakeup and selection
    // ########################################################################

    // A source counts as ready once its register has been seen not pending.
    // The flag sticks, so an entry that writes its own source does not wait
    // on itself.
    always_comb begin
        for (int i = 0; i < L; i++) begin
            slot_rdy[i] = vld[i] &
                (~slots[i].use_ra | slots[i].ra_ok | ~pending[slots[i].ra_addr]) &
                (~slots[i].use_rt | slots[i].rt_ok | ~pending[slots[i].rt_addr]);
        end
    end

    // Scanning downward leaves the lowest index in the select registers.
    always_comb begin
        any_rdy  = 1'b0;
        sel_idx  = '0;
        any_open = 1'b0;
        open_idx = '0;
        src_busy = '0;
        for (int i = L - 1; i >= 0; i--) begin
            if (slot_rdy[i]) begin
                any_rdy = 1'b1;
                sel_idx = IDX_W'(i);
            end
            if (!vld[i]) begin
                any_open = 1'b1;
                open_idx = IDX_W'(i);
            end else begin
                if (slots[i].use_ra) src_busy[slots[i].ra_addr] = 1'b1;
                if (slots[i].use_rt) src_busy[slots[i].rt_addr] = 1'b1;
            end
        end
    end

    assign in.ready    = any_open;
    assign fill        = in.valid & in.ready;
    assign issue_fire  = out.valid & out.ready;

    assign out.valid   = any_rdy;
    assign out.alu_op  = slots[sel_idx].alu_op;
    assign out.immdt   = slots[sel_idx].immdt;
    assign out.use_ra  = slots[sel_idx].use_ra;
    assign out.ra_addr = slots[sel_idx].ra_addr;
    assign out.use_rt  = slots[sel_idx].use_rt;
    assign out.rt_addr = slots[sel_idx].rt_addr;
    assign out.rw_addr = slots[sel_idx].rw_addr;

    // ########################################################################
    // Entry storage
    // ########################################################################

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            vld <= '0;
        end else begin
            for (int i = 0; i < L; i++) begin
                if (issue_fire && sel_idx == IDX_W'(i)) vld[i] <= 1'b0;
                if (fill && open_idx == IDX_W'(i)) vld[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < L; i++) begin
            slots[i].ra_ok <= slots[i].ra_ok | ~pending[slots[i].ra_addr];
            slots[i].rt_ok <= slots[i].rt_ok | ~pending[slots[i].rt_addr];
            if (fill && open_idx == IDX_W'(i)) begin
                slots[i] <= '{
                    alu_op:  in.alu_op,
                    immdt:   in.immdt,
                    use_ra:  in.use_ra,
                    ra_addr: in.ra_addr,
                    ra_ok:   ~pending[in.ra_addr],
                    use_rt:  in.use_rt,
                    rt_addr: in.rt_addr,
                    rt_ok:   ~pending[in.rt_addr],
                    rw_addr: in.rw_addr
                };
            end
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int NUM_REGS = nand_cpu_pkg::NUM_REGS
) (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic [nand_cpu_pkg::REG_AW-1:0]  rd_a_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]  rd_a_data,
    input  logic [nand_cpu_pkg::REG_AW-1:0]  rd_b_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]  rd_b_data,
    input  logic [nand_cpu_pkg::REG_AW-1:0]  dbg_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]  dbg_data,
    input  logic                             wr_en,
    input  logic [nand_cpu_pkg::REG_AW-1:0]  wr_addr,
    input  logic [nand_cpu_pkg::DATA_W-1:0]  wr_data,
    input  logic                             reserve_en,
    input  logic [nand_cpu_pkg::REG_AW-1:0]  reserve_addr,
    output logic [NUM_REGS-1:0]              pending
);
    import nand_cpu_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    assign rd_a_data = regs[rd_a_addr];
    assign rd_b_data = regs[rd_b_addr];
    assign dbg_data  = regs[dbg_addr];

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            regs    <= '{default: '0};
            pending <= '0;
        end else begin
            if (reserve_en) begin
                pending[reserve_addr] <= 1'b1;
            end
            // The write comes last so it wins over a reservation of the
            // same register.
            if (wr_en) begin
                regs[wr_addr]    <= wr_data;
                pending[wr_addr] <= 1'b0;
            end
        end
    end

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                             clk,
    input  logic                             n_rst,
    issue_ifc.receiver                       issue,
    output logic [nand_cpu_pkg::REG_AW-1:0]  rd_a_addr,
    output logic [nand_cpu_pkg::REG_AW-1:0]  rd_b_addr,
    input  logic [nand_cpu_pkg::DATA_W-1:0]  rd_a_data,
    input  logic [nand_cpu_pkg::DATA_W-1:0]  rd_b_data,
    output logic                             wr_en,
    output logic [nand_cpu_pkg::REG_AW-1:0]  wr_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]  wr_data,
    output logic                             busy
);
    import nand_cpu_pkg::*;

    // The multiplier consumes one digit of rt per cycle.
    localparam int DIGIT = DATA_W / MUL_CYCLES;
    localparam int CNT_W = $clog2(MUL_CYCLES);

    logic              fire;
    logic              in_flight;
    logic [CNT_W-1:0]  cnt;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_zext;
    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] result;
    logic [DATA_W-1:0] mcand;
    logic [DATA_W-1:0] mplier;
    logic [DATA_W-1:0] partial;

    assign rd_a_addr   = issue.ra_addr;
    assign rd_b_addr   = issue.rt_addr;
    assign issue.ready = ~in_flight;
    assign fire        = issue.valid & issue.ready;
    assign busy        = in_flight;

    assign imm_sext = {{(DATA_W - IMM_W){issue.immdt[IMM_W-1]}}, issue.immdt};
    assign imm_zext = {{(DATA_W - IMM_W){1'b0}}, issue.immdt};

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  alu_res = rd_a_data + rd_b_data;
            ALU_NAND: alu_res = ~(rd_a_data & rd_b_data);
            ALU_ADDI: alu_res = rd_a_data + imm_sext;
            ALU_LI:   alu_res = imm_zext;
            ALU_MUL:  alu_res = rd_a_data * {{(DATA_W - DIGIT){1'b0}}, rd_b_data[DIGIT-1:0]};
            default:  alu_res = '0;
        endcase
    end

    assign partial = mcand * {{(DATA_W - DIGIT){1'b0}}, mplier[DIGIT-1:0]};

    // ########################################################################
    // Sequencing
    // ########################################################################

    // Single-cycle operations leave the counter at zero and write back in
    // the next cycle. A multiply counts down once per remaining digit.
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            in_flight <= 1'b0;
            cnt       <= '0;
        end else if (fire) begin
            in_flight <= 1'b1;
            cnt       <= (issue.alu_op == ALU_MUL) ? CNT_W'(MUL_CYCLES - 1) : '0;
        end else if (in_flight) begin
            if (cnt == '0) begin
                in_flight <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            result  <= alu_res;
            mcand   <= rd_a_data << DIGIT;
            mplier  <= rd_b_data >> DIGIT;
            wr_addr <= issue.rw_addr;
        end else if (in_flight && cnt != '0) begin
            result <= result + partial;
            mcand  <= mcand << DIGIT;
            mplier <= mplier >> DIGIT;
        end
    end

    assign wr_en   = in_flight & (cnt == '0);
    assign wr_data = result;

endmodule

// File: logic/nand_core.sv
`timescale 1ns/1ps

module nand_core #(
    parameter int L        = 8,
    parameter int NUM_REGS = nand_cpu_pkg::NUM_REGS
) (
    input  logic                             clk,
    input  logic                             n_rst,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [31:0]                      wb_dat_i,
    output logic                             wb_ack,
    output logic                             retire_valid,
    output logic [nand_cpu_pkg::REG_AW-1:0]  retire_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]  retire_data,
    input  logic [nand_cpu_pkg::REG_AW-1:0]  dbg_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]  dbg_data,
    output logic                             idle
);
    import nand_cpu_pkg::*;

    logic [NUM_REGS-1:0] pending;
    logic [NUM_REGS-1:0] src_busy;
    logic                reserve_en;
    logic [REG_AW-1:0]   reserve_addr;
    logic [REG_AW-1:0]   rd_a_addr;
    logic [REG_AW-1:0]   rd_b_addr;
    logic [DATA_W-1:0]   rd_a_data;
    logic [DATA_W-1:0]   rd_b_data;
    logic                wr_en;
    logic [REG_AW-1:0]   wr_addr;
    logic [DATA_W-1:0]   wr_data;
    logic                exec_busy;

    issue_ifc dispatch_ifc ();
    issue_ifc issue_bus ();

    wb_dispatch #(
        .NUM_REGS(NUM_REGS)
    ) u_dispatch (
        .clk         (clk),
        .n_rst       (n_rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .pending     (pending),
        .src_busy    (src_busy),
        .reserve_en  (reserve_en),
        .reserve_addr(reserve_addr),
        .dispatch    (dispatch_ifc.sender)
    );

    execution_buffer #(
        .L       (L),
        .NUM_REGS(NUM_REGS)
    ) u_buffer (
        .clk     (clk),
        .n_rst   (n_rst),
        .pending (pending),
        .src_busy(src_busy),
        .in      (dispatch_ifc.receiver),
        .out     (issue_bus.sender)
    );

    reg_file #(
        .NUM_REGS(NUM_REGS)
    ) u_regs (
        .clk         (clk),
        .n_rst       (n_rst),
        .rd_a_addr   (rd_a_addr),
        .rd_a_data   (rd_a_data),
        .rd_b_addr   (rd_b_addr),
        .rd_b_data   (rd_b_data),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .reserve_en  (reserve_en),
        .reserve_addr(reserve_addr),
        .pending     (pending)
    );

    exec_unit u_exec (
        .clk      (clk),
        .n_rst    (n_rst),
        .issue    (issue_bus.receiver),
        .rd_a_addr(rd_a_addr),
        .rd_b_addr(rd_b_addr),
        .rd_a_data(rd_a_data),
        .rd_b_data(rd_b_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .busy     (exec_busy)
    );

    assign retire_valid = wr_en;
    assign retire_addr  = wr_addr;
    assign retire_data  = wr_data;

    // Every queued entry holds its destination pending, so a clear pending
    // vector also means the buffer is empty.
    assign idle = ~exec_busy & ~(|pending) & ~dispatch_ifc.valid;

endmodule

// File: test/tb_nand_core.sv
`timescale 1ns/1ps

module tb_nand_core;
    import nand_cpu_pkg::*;

    localparam int BUF_DEPTH  = 4;
    localparam int RAND_LEN   = 40;
    localparam int NUM_INSTR  = 24 + RAND_LEN;
    localparam int MAX_CYCLES = 20 * NUM_INSTR + 200;

    logic              clk;
    logic              n_rst;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [31:0]       wb_dat_i;
    logic              wb_ack;
    logic              retire_valid;
    logic [REG_AW-1:0] retire_addr;
    logic [DATA_W-1:0] retire_data;
    logic [REG_AW-1:0] dbg_addr;
    logic [DATA_W-1:0] dbg_data;
    logic              idle;

    logic [DATA_W-1:0] golden  [NUM_REGS];
    logic [DATA_W-1:0] exp_val [NUM_REGS];
    logic [DATA_W-1:0] exp_now;
    logic [NUM_REGS-1:0] outstanding;
    int                retire_cycle [NUM_REGS];
    int                cycle = 0;
    int                ack_cycle;
    int                errors;
    int                sent;
    int                test_no;
    int                test_err0;
    logic [15:0]       lfsr;

    nand_core #(
        .L       (BUF_DEPTH),
        .NUM_REGS(NUM_REGS)
    ) DUT (
        .clk         (clk),
        .n_rst       (n_rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .retire_valid(retire_valid),
        .retire_addr (retire_addr),
        .retire_data (retire_data),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .idle        (idle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // A retire must belong to a register with an acknowledged write still open.
    always @(negedge clk) begin
        if (n_rst && retire_valid) begin
            retire_cycle[retire_addr] = cycle;
            assert (outstanding[retire_addr]) else begin
                errors++;
                $display("Retire on r%0d with no write outstanding to it", retire_addr);
            end
            outstanding[retire_addr] = 1'b0;
        end
    end

    // ########################################################################
    // Assertions
    // ########################################################################

    // Each register has at most one write in flight, so the value expected
    // for it was fixed when its instruction was acknowledged.
    assign exp_now = exp_val[retire_addr];

    ack_single: assert property (@(posedge clk) disable iff (!n_rst) wb_ack |=> !wb_ack)
        else begin
            errors++;
            $display("wb_ack stayed high for more than one cycle");
        end

    ack_with_stb: assert property (@(posedge clk) disable iff (!n_rst)
            wb_ack |-> (wb_cyc && wb_stb))
        else begin
            errors++;
            $display("wb_ack came without an active strobe");
        end

    retire_value: assert property (@(posedge clk) disable iff (!n_rst)
            retire_valid |-> (retire_data == exp_now))
        else begin
            errors++;
            $display("MISMATCH retire_data r%0d: got %h expected %h", $sampled(retire_addr),
                     $sampled(retire_data), $sampled(exp_now));
        end

    // ########################################################################
    // Stimulus helpers and reference model
    // ########################################################################

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] model_result(alu_op_t op, logic [DATA_W-1:0] a,
                                                       logic [DATA_W-1:0] b,
                                                       logic [IMM_W-1:0] imm);
        logic [2*DATA_W-1:0] full;
        full = a * b;
        case (op)
            ALU_ADD:  return a + b;
            ALU_NAND: return ~(a & b);
            ALU_ADDI: return a + DATA_W'($signed(imm));
            ALU_LI:   return DATA_W'(imm);
            ALU_MUL:  return full[DATA_W-1:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic [INSTR_W-1:0] encode(alu_op_t op, int rw, int ra, int rt,
                                                 logic [IMM_W-1:0] imm);
        logic [INSTR_W-1:0] w;
        w = '0;
        w[OP_POS +: OP_W]   = op;
        w[RW_POS +: REG_AW] = REG_AW'(rw);
        w[RA_POS +: REG_AW] = REG_AW'(ra);
        w[RT_POS +: REG_AW] = REG_AW'(rt);
        w[IMM_POS +: IMM_W] = imm;
        return w;
    endfunction

    // Starts and ends 1 ns after a rising edge.
    task automatic send(alu_op_t op, int rw, int ra, int rt, logic [IMM_W-1:0] imm);
        logic [DATA_W-1:0] res;
        res      = model_result(op, golden[ra], golden[rt], imm);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_i = 32'(encode(op, rw, ra, rt, imm));
        do @(negedge clk); while (!wb_ack);
        ack_cycle   = cycle;
        sent++;
        golden[rw]  = res;
        exp_val[rw] = res;
        outstanding[rw] = 1'b1;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (!idle);
        check_true(outstanding == '0, "an acknowledged write never retired");
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            errors++;
            $display("Check failed: %s", what);
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            dbg_addr = REG_AW'(r);
            @(negedge clk);
            check_val($sformatf("dbg_data r%0d", r), 32'(dbg_data), 32'(golden[r]));
            @(posedge clk);
            #1;
        end
    endtask

    task automatic begin_test();
        test_no++;
        test_err0 = errors;
    endtask

    task automatic end_test(string name);
        $display("Test %0d %s: %0d errors", test_no, name, errors - test_err0);
    endtask

    // ########################################################################
    // Test sequence
    // ########################################################################

    initial begin : main_seq
        int                t0;
        int                rw;
        int                ra;
        int                rt;
        logic [IMM_W-1:0]  imm;
        alu_op_t           op;
        n_rst    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_i = '0;
        dbg_addr = '0;
        lfsr     = 16'd30085;
        errors   = 0;
        sent     = 0;
        test_no  = 0;
        outstanding = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            golden[r]       = '0;
            exp_val[r]      = '0;
            retire_cycle[r] = 0;
        end
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;

        begin_test();
        @(negedge clk);
        check_val("wb_ack", 32'(wb_ack), 32'd0);
        check_val("retire_valid", 32'(retire_valid), 32'd0);
        check_val("idle", 32'(idle), 32'd1);
        @(posedge clk);
        #1;
        check_regs();
        end_test("reset state");

        // ADDI adds -5 and the MUL squares 0xffd2, which wraps.
        begin_test();
        send(ALU_LI, 2, 0, 0, 6'h3f);
        send(ALU_LI, 3, 0, 0, 6'h2d);
        send(ALU_ADDI, 4, 2, 0, 6'h3b);
        send(ALU_ADD, 5, 2, 3, 6'h00);
        send(ALU_NAND, 6, 2, 3, 6'h00);
        send(ALU_MUL, 7, 6, 6, 6'h00);
        wait_idle();
        check_regs();
        end_test("single operations");

        // The MUL on r4 sits behind a two-deep multiply chain, so the LI
        // lands in a lower slot and overtakes it.
        begin_test();
        t0 = cycle;
        send(ALU_MUL, 1, 2, 3, 6'h00);
        send(ALU_MUL, 7, 1, 2, 6'h00);
        send(ALU_MUL, 4, 7, 3, 6'h00);
        send(ALU_ADD, 5, 4, 2, 6'h00);
        send(ALU_LI, 6, 0, 0, 6'h15);
        wait_idle();
        check_true(retire_cycle[6] > t0 && retire_cycle[6] < retire_cycle[4],
                   "the LI did not retire before the MUL");
        check_true(retire_cycle[4] < retire_cycle[5],
                   "the dependent ADD retired before the MUL");
        check_regs();
        end_test("retire order");

        begin_test();
        t0 = cycle;
        send(ALU_MUL, 7, 2, 3, 6'h00);
        send(ALU_MUL, 6, 7, 7, 6'h00);
        send(ALU_MUL, 1, 6, 6, 6'h00);
        for (int i = 0; i < BUF_DEPTH; i++) send(ALU_ADD, 2 + i, 1, 1, 6'h00);
        send(ALU_LI, 0, 0, 0, 6'h11);
        check_true(retire_cycle[1] > t0 && ack_cycle > retire_cycle[1],
                   "a write was acknowledged while the buffer was full");
        wait_idle();
        check_regs();
        end_test("back-pressure");

        begin_test();
        t0 = cycle;
        send(ALU_MUL, 1, 2, 3, 6'h00);
        send(ALU_LI, 1, 0, 0, 6'h05);
        check_true(retire_cycle[1] > t0 && ack_cycle > retire_cycle[1],
                   "a write to a pending register was acknowledged early");
        t0 = cycle;
        send(ALU_MUL, 4, 2, 3, 6'h00);
        send(ALU_ADD, 5, 4, 6, 6'h00);
        send(ALU_LI, 6, 0, 0, 6'h09);
        check_true(retire_cycle[4] > t0 && ack_cycle > retire_cycle[4],
                   "a write to a register read by a waiting entry was acknowledged early");
        wait_idle();
        check_regs();
        end_test("register hazards");

        begin_test();
        for (int n = 0; n < RAND_LEN; n++) begin
            op  = alu_op_t'(3'(take_bits(OP_W) % 5));
            rw  = take_bits(REG_AW);
            ra  = take_bits(REG_AW);
            rt  = take_bits(REG_AW);
            imm = IMM_W'(take_bits(IMM_W));
            send(op, rw, ra, rt, imm);
        end
        wait_idle();
        check_regs();
        end_test("random program");

        $display("Tests run: %0d, instructions sent: %0d, errors: %0d", test_no, sent, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: nand_core.f
common/nand_cpu_pkg.sv
common/issue_ifc.sv
logic/wb_dispatch.sv
execution_buffer/execution_buffer.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/nand_core.sv
test/tb_nand_core.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and fail unless the testbench reports a pass.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_nand_core -f nand_core.f &&
./obj_dir/Vtb_nand_core | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run.sh: simulation run succeeded" ||
{ echo "run.sh: simulation run failed"; exit 1; }
